// File: design/branch_decoder.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module branch_decoder
    import mips_core_pkg::*;
(
    input  logic [`ADDR_WIDTH-1:0] i_pc,
    input  instr_word_u            i_instr,
    output logic                   o_is_branch,
    output logic                   o_is_jump,
    output logic [`ADDR_WIDTH-1:0] o_target
);

    logic [`ADDR_WIDTH-1:0] pc_plus4;
    logic [`ADDR_WIDTH-1:0] branch_offset;
    logic [`ADDR_WIDTH-1:0] branch_target;
    logic [`ADDR_WIDTH-1:0] jump_target;

    assign pc_plus4 = i_pc + `ADDR_WIDTH'(4);

    // sign-extended word offset from the I-type view
    assign branch_offset = {{(`ADDR_WIDTH-18){i_instr.i_type.imm[15]}},
                            i_instr.i_type.imm, 2'b00};
    assign branch_target = pc_plus4 + branch_offset;

    // region of pc+4 with the J-type index appended
    assign jump_target = {pc_plus4[`ADDR_WIDTH-1:28], i_instr.j_type.target, 2'b00};

    always_comb begin
        o_is_branch = 1'b0;
        o_is_jump   = 1'b0;
        case (i_instr.i_type.opcode)
            BEQ, BNE, BLEZ, BGTZ: begin
                o_is_branch = 1'b1;
            end
            J, JAL: begin
                o_is_jump = 1'b1;
            end
            default: begin
                o_is_branch = 1'b0;
                o_is_jump   = 1'b0;
            end
        endcase
    end

    always_comb begin
        if (o_is_branch) begin
            o_target = branch_target;
        end else if (o_is_jump) begin
            o_target = jump_target;
        end else begin
            // fall-through address for anything else
            o_target = pc_plus4;
        end
    end

    a_kind_exclusive: assert final (!(o_is_branch && o_is_jump))
        else $error("decoder flagged a word as both branch and jump");

endmodule

// File: design/branch_predict_unit.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module branch_predict_unit
    import mips_core_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   i_req_valid,
    input  logic [`ADDR_WIDTH-1:0] i_req_pc,
    input  instr_word_u            i_req_instr,

    input  logic                   i_fb_valid,
    input  logic [`ADDR_WIDTH-1:0] i_fb_pc,
    input  branch_outcome_t        i_fb_prediction,
    input  branch_outcome_t        i_fb_outcome,

    output logic                   o_pred_valid,
    output logic                   o_pred_kind_branch,
    output logic                   o_pred_kind_jump,
    output logic [`ADDR_WIDTH-1:0] o_pred_target,
    output branch_outcome_t        o_pred_dir
);

    logic                   dec_is_branch;
    logic                   dec_is_jump;
    logic [`ADDR_WIDTH-1:0] dec_target;
    logic [`GHR_LEN-1:0]    ghr;
    branch_outcome_t        pp_dir;

    logic                   valid_q;
    logic                   branch_q;
    logic                   jump_q;
    logic [`ADDR_WIDTH-1:0] target_q;

    branch_decoder u_decoder (
        .i_pc        (i_req_pc),
        .i_instr     (i_req_instr),
        .o_is_branch (dec_is_branch),
        .o_is_jump   (dec_is_jump),
        .o_target    (dec_target)
    );

    global_history u_history (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_fb_valid   (i_fb_valid),
        .i_fb_outcome (i_fb_outcome),
        .o_ghr        (ghr)
    );

    perceptron_predictor u_predictor (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req_valid     (i_req_valid),
        .i_req_pc        (i_req_pc),
        .i_ghr           (ghr),
        .o_pred_dir      (pp_dir),
        .i_fb_valid      (i_fb_valid),
        .i_fb_pc         (i_fb_pc),
        .i_fb_prediction (i_fb_prediction),
        .i_fb_outcome    (i_fb_outcome)
    );

    // decode results line up with the registered direction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            branch_q <= 1'b0;
            jump_q   <= 1'b0;
            target_q <= '0;
        end else begin
            valid_q <= i_req_valid;
            if (i_req_valid) begin
                branch_q <= dec_is_branch;
                jump_q   <= dec_is_jump;
                target_q <= dec_target;
            end
        end
    end

    assign o_pred_valid       = valid_q;
    assign o_pred_kind_branch = branch_q;
    assign o_pred_kind_jump   = jump_q;
    assign o_pred_target      = target_q;

    // jumps always go, non-branches never do
    assign o_pred_dir = branch_q ? pp_dir : (jump_q ? TAKEN : NOT_TAKEN);

endmodule

// File: design/global_history.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module global_history
    import mips_core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_fb_valid,
    input  branch_outcome_t     i_fb_outcome,
    output logic [`GHR_LEN-1:0] o_ghr
);

    logic [`GHR_LEN-1:0] ghr_q;

    // newest outcome lands in bit 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (i_fb_valid) begin
            ghr_q <= {ghr_q[`GHR_LEN-2:0], i_fb_outcome == TAKEN};
        end
    end

    assign o_ghr = ghr_q;

    a_fb_outcome_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_fb_valid |-> !$isunknown(i_fb_outcome)
    ) else $error("feedback outcome unknown while strobe is high");

endmodule

// File: design/mips_core_pkg.sv
package mips_core_pkg;

    // resolved or predicted branch direction
    typedef enum logic {
        NOT_TAKEN = 1'b0,
        TAKEN     = 1'b1
    } branch_outcome_t;

    // control transfer opcodes
    typedef enum logic [5:0] {
        J    = 6'h02,
        JAL  = 6'h03,
        BEQ  = 6'h04,
        BNE  = 6'h05,
        BLEZ = 6'h06,
        BGTZ = 6'h07
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } j_type_t;

    // one fetched word, viewed as either format
    typedef union packed {
        i_type_t i_type;
        j_type_t j_type;
    } instr_word_u;

endpackage

// File: design/perceptron_predictor.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module perceptron_predictor
    import mips_core_pkg::*;
    import predictor_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   i_req_valid,
    input  logic [`ADDR_WIDTH-1:0] i_req_pc,
    input  logic [`GHR_LEN-1:0]    i_ghr,
    output branch_outcome_t        o_pred_dir,

    input  logic                   i_fb_valid,
    input  logic [`ADDR_WIDTH-1:0] i_fb_pc,
    input  branch_outcome_t        i_fb_prediction,
    input  branch_outcome_t        i_fb_outcome
);

    localparam int WEIGHT_COUNT = `GHR_LEN + 1;
    localparam int IDX_BITS     = $bits(pht_index_t);

    localparam weight_t W_MAX = weight_t'((1 << (`WEIGHT_BITS-1)) - 1);
    localparam weight_t W_MIN = weight_t'(-(1 << (`WEIGHT_BITS-1)));

    localparam perceptron_sum_t THRESHOLD = perceptron_sum_t'(`TRAIN_THRESHOLD);

    // weight 0 of each row is the bias
    weight_t weights [`PERCEPTRON_COUNT][WEIGHT_COUNT];

    pht_index_t req_idx;
    pht_index_t fb_idx;

    // history inputs with a constant 1 for the bias
    logic [WEIGHT_COUNT-1:0] hist_x;

    perceptron_sum_t req_sum;
    perceptron_sum_t fb_sum;
    perceptron_sum_t fb_mag;

    logic [WEIGHT_COUNT-1:0] step_up;
    logic                    train;

    branch_outcome_t pred_q;

    function automatic pht_index_t hash_index(
        input logic [`ADDR_WIDTH-1:0] pc,
        input logic [`GHR_LEN-1:0]    ghr
    );
        return pc[IDX_BITS+1:2] ^ ghr[IDX_BITS-1:0];
    endfunction

    // +w where the input bit is 1, -w where it is 0
    function automatic perceptron_sum_t dot_product(
        input weight_t                 row [WEIGHT_COUNT],
        input logic [WEIGHT_COUNT-1:0] x
    );
        perceptron_sum_t acc;
        acc = '0;
        for (int j = 0; j < WEIGHT_COUNT; j++) begin
            if (x[j]) begin
                acc = acc + perceptron_sum_t'(row[j]);
            end else begin
                acc = acc - perceptron_sum_t'(row[j]);
            end
        end
        return acc;
    endfunction

    function automatic weight_t sat_step(input weight_t w, input logic up);
        weight_t res;
        if (up) begin
            res = (w == W_MAX) ? w : w + weight_t'(1);
        end else begin
            res = (w == W_MIN) ? w : w - weight_t'(1);
        end
        return res;
    endfunction

    assign hist_x  = {i_ghr, 1'b1};
    assign req_idx = hash_index(i_req_pc, i_ghr);
    assign fb_idx  = hash_index(i_fb_pc, i_ghr);

    assign req_sum = dot_product(weights[req_idx], hist_x);
    assign fb_sum  = dot_product(weights[fb_idx], hist_x);
    assign fb_mag  = (fb_sum < 0) ? -fb_sum : fb_sum;

    // weight moves toward agreement between its input and the outcome
    assign step_up = (i_fb_outcome == TAKEN) ? hist_x : ~hist_x;

    // mispredicted, or not yet confident enough
    assign train = (i_fb_prediction != i_fb_outcome) || (fb_mag <= THRESHOLD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PERCEPTRON_COUNT; i++) begin
                for (int j = 0; j < WEIGHT_COUNT; j++) begin
                    weights[i][j] <= '0;
                end
            end
        end else if (i_fb_valid && train) begin
            for (int j = 0; j < WEIGHT_COUNT; j++) begin
                weights[fb_idx][j] <= sat_step(weights[fb_idx][j], step_up[j]);
            end
        end
    end

    // zero sum counts as taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_q <= NOT_TAKEN;
        end else if (i_req_valid) begin
            pred_q <= (req_sum >= 0) ? TAKEN : NOT_TAKEN;
        end
    end

    assign o_pred_dir = pred_q;

    // a weight pinned at its limit holds there when pushed further
    for (genvar j = 0; j < WEIGHT_COUNT; j++) begin : g_sat_chk
        a_weight_saturates: assert property (
            @(posedge clk) disable iff (!rst_n)
            (i_fb_valid && train &&
             ((step_up[j] && weights[fb_idx][j] == W_MAX) ||
              (!step_up[j] && weights[fb_idx][j] == W_MIN)))
            |=> (weights[$past(fb_idx)][j] == $past(weights[fb_idx][j]))
        ) else $error("weight %0d moved past its saturation limit", j);
    end

endmodule

// File: design/predictor_consts.svh
`ifndef PREDICTOR_CONSTS_SVH
`define PREDICTOR_CONSTS_SVH

// pc and target width
`define ADDR_WIDTH 32

// global history length in bits
`define GHR_LEN 8

// number of perceptrons in the table
`define PERCEPTRON_COUNT 64

// signed weight width
`define WEIGHT_BITS 8

// integer part of 1.93 * history length + 14
`define TRAIN_THRESHOLD (((193 * `GHR_LEN) / 100) + 14)

`endif

// File: design/predictor_pkg.sv
`include "predictor_consts.svh"

package predictor_pkg;

    // one perceptron weight
    typedef logic signed [`WEIGHT_BITS-1:0] weight_t;

    // row select into the weight table
    typedef logic [$clog2(`PERCEPTRON_COUNT)-1:0] pht_index_t;

    // holds bias plus GHR_LEN weighted terms
    typedef logic signed [15:0] perceptron_sum_t;

endpackage

// File: files.f
+incdir+design
design/mips_core_pkg.sv
design/predictor_pkg.sv
design/branch_decoder.sv
design/global_history.sv
design/perceptron_predictor.sv
design/branch_predict_unit.sv
tb/tb_branch_predict_unit.sv

// File: tb/branch_testdata.txt
# op pc instr fb_outcome fb_prediction kind(branch,jump) target dir
# 1 means TAKEN in outcome, prediction and dir; unused fields are 0
R 00400000 10220010 0 0 10 00400044 1
R 00400100 1460fff8 0 0 10 004000e4 1
R 00400020 1000ffff 0 0 10 00400020 1
R 00400200 08100040 0 0 01 00400100 1
R 1ffffffc 0c000010 0 0 01 20000040 1
R 00400300 00221821 0 0 00 00400304 0
R 00400304 24210001 0 0 00 00400308 0
F 00400000 00000000 0 1 00 00000000 0
R 00400000 10220010 0 0 10 00400044 0
R 00400004 10220010 0 0 10 00400048 1
F 00400014 00000000 1 1 00 00000000 0
R 00400004 10220010 0 0 10 00400048 0
R 00400010 1460fff8 0 0 10 003ffff4 1
R 00400000 10220010 0 0 10 00400044 1
R 00400008 08100040 0 0 01 00400100 1
R 0040000c 00221821 0 0 00 00400010 0

// File: tb/tb_branch_predict_unit.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module tb_branch_predict_unit
    import mips_core_pkg::*;
();

    localparam int MAX_LINES      = 64;
    localparam int TIMEOUT_CYCLES = 16;

    logic                   clk;
    logic                   rst_n;
    logic                   i_req_valid;
    logic [`ADDR_WIDTH-1:0] i_req_pc;
    instr_word_u            i_req_instr;
    logic                   i_fb_valid;
    logic [`ADDR_WIDTH-1:0] i_fb_pc;
    branch_outcome_t        i_fb_prediction;
    branch_outcome_t        i_fb_outcome;
    logic                   o_pred_valid;
    logic                   o_pred_kind_branch;
    logic                   o_pred_kind_jump;
    logic [`ADDR_WIDTH-1:0] o_pred_target;
    branch_outcome_t        o_pred_dir;

    // one entry per data line
    logic [7:0]             op_col     [MAX_LINES];
    logic [`ADDR_WIDTH-1:0] pc_col     [MAX_LINES];
    logic [31:0]            instr_col  [MAX_LINES];
    logic                   outcome_col[MAX_LINES];
    logic                   pred_col   [MAX_LINES];
    logic [1:0]             kind_col   [MAX_LINES];
    logic [`ADDR_WIDTH-1:0] target_col [MAX_LINES];
    logic                   dir_col    [MAX_LINES];

    int n_lines;
    int pass_count;
    int fail_count;
    bit timed_out;

    branch_predict_unit dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_req_valid        (i_req_valid),
        .i_req_pc           (i_req_pc),
        .i_req_instr        (i_req_instr),
        .i_fb_valid         (i_fb_valid),
        .i_fb_pc            (i_fb_pc),
        .i_fb_prediction    (i_fb_prediction),
        .i_fb_outcome       (i_fb_outcome),
        .o_pred_valid       (o_pred_valid),
        .o_pred_kind_branch (o_pred_kind_branch),
        .o_pred_kind_jump   (o_pred_kind_jump),
        .o_pred_target      (o_pred_target),
        .o_pred_dir         (o_pred_dir)
    );

    always #4 clk = ~clk;

    task automatic load_testdata;
        int          fd;
        int          ch;
        int          code;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] outcome;
        logic [31:0] pred;
        logic [1:0]  kind;
        logic [31:0] target;
        logic [31:0] dir;
        fd = $fopen("tb/branch_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/branch_testdata.txt");
            fail_count++;
        end else begin
            ch = $fgetc(fd);
            while (ch != -1 && n_lines < MAX_LINES) begin
                if (ch == "#") begin
                    // skip the rest of a comment line
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (ch == "R" || ch == "F") begin
                    code = $fscanf(fd, "%h %h %d %d %b %h %d",
                                   pc, instr, outcome, pred, kind, target, dir);
                    if (code == 7) begin
                        op_col[n_lines]      = ch[7:0];
                        pc_col[n_lines]      = pc;
                        instr_col[n_lines]   = instr;
                        outcome_col[n_lines] = outcome[0];
                        pred_col[n_lines]    = pred[0];
                        kind_col[n_lines]    = kind;
                        target_col[n_lines]  = target;
                        dir_col[n_lines]     = dir[0];
                        n_lines++;
                    end else begin
                        $display("malformed line after entry %0d in the data file", n_lines);
                        fail_count++;
                    end
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_kind(input logic [1:0] got, input logic [1:0] exp,
                              input int line_no, inout bit ok);
        if (got !== exp) begin
            $display("MISMATCH at %0t: line %0d kind {branch,jump} got %b expected %b",
                     $time, line_no, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_target(input logic [`ADDR_WIDTH-1:0] got,
                                input logic [`ADDR_WIDTH-1:0] exp,
                                input int line_no, inout bit ok);
        if (got !== exp) begin
            $display("MISMATCH at %0t: line %0d target got %h expected %h",
                     $time, line_no, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_dir(input branch_outcome_t got, input branch_outcome_t exp,
                             input int line_no, inout bit ok);
        if (got !== exp) begin
            $display("MISMATCH at %0t: line %0d direction got %s expected %s",
                     $time, line_no, got.name(), exp.name());
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input int line_no, input bit ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test line %0d pc=%h: %s", line_no, pc_col[line_no], ok ? "ok" : "FAIL");
    endtask

    // requests go out back to back, results come back one cycle later in order
    task automatic run_requests(input int first, input int count);
        int issued;
        int checked;
        int idle;
        int k;
        bit ok;
        bit due;
        issued  = 0;
        checked = 0;
        idle    = 0;
        while (checked < count && !timed_out) begin
            @(posedge clk);
            // a request driven last cycle is sampled at this edge
            due = (issued > checked);
            if (issued < count) begin
                k = first + issued;
                i_req_valid <= 1'b1;
                i_req_pc    <= pc_col[k];
                i_req_instr <= instr_word_u'(instr_col[k]);
                issued++;
            end else begin
                i_req_valid <= 1'b0;
            end
            @(negedge clk);
            if (o_pred_valid) begin
                k  = first + checked;
                ok = 1'b1;
                check_kind({o_pred_kind_branch, o_pred_kind_jump}, kind_col[k], k, ok);
                check_target(o_pred_target, target_col[k], k, ok);
                check_dir(o_pred_dir, branch_outcome_t'(dir_col[k]), k, ok);
                report_test(k, ok);
                checked++;
                idle = 0;
            end else if (due) begin
                $display("prediction for data line %0d was not ready one cycle after its request",
                         first + checked);
                timed_out = 1'b1;
            end else begin
                idle++;
                if (idle > TIMEOUT_CYCLES) begin
                    $display("prediction for data line %0d never arrived", first + checked);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic apply_feedback(input int k);
        @(posedge clk);
        i_fb_valid      <= 1'b1;
        i_fb_pc         <= pc_col[k];
        i_fb_outcome    <= branch_outcome_t'(outcome_col[k]);
        i_fb_prediction <= branch_outcome_t'(pred_col[k]);
        @(posedge clk);
        i_fb_valid <= 1'b0;
        $display("feedback line %0d pc=%h outcome=%0d prediction=%0d",
                 k, pc_col[k], outcome_col[k], pred_col[k]);
    endtask

    initial begin
        int idx;
        int burst;
        clk             = 1'b0;
        rst_n           = 1'b0;
        i_req_valid     = 1'b0;
        i_req_pc        = '0;
        i_req_instr     = '0;
        i_fb_valid      = 1'b0;
        i_fb_pc         = '0;
        i_fb_prediction = NOT_TAKEN;
        i_fb_outcome    = NOT_TAKEN;
        n_lines         = 0;
        pass_count      = 0;
        fail_count      = 0;
        timed_out       = 1'b0;
        load_testdata();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idx = 0;
        while (idx < n_lines && !timed_out) begin
            if (op_col[idx] == "F") begin
                apply_feedback(idx);
                idx++;
            end else begin
                // consecutive request lines form one burst
                burst = 0;
                while (idx + burst < n_lines && op_col[idx + burst] == "R") begin
                    burst++;
                end
                run_requests(idx, burst);
                idx += burst;
            end
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (timed_out || fail_count != 0 || pass_count == 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule
